// File: dv/matrix_asserts.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module matrix_asserts (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  tx_start,
    input logic                  tx_busy,
    input matrix_pkg::store_wr_t wr,
    input logic                  uart_tx
);

    // =========================================================================
    // reply path
    // =========================================================================
    // no new byte while a frame is on the line
    start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start raised while the transmitter is busy");

    // idle line stays at the mark level
    line_high_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !tx_busy |-> uart_tx)
        else $error("serial output low while the transmitter is idle");

    // element index inside one slot
    wr_idx_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        wr.valid |-> (wr.idx < 4'(`MAX_DIM * `MAX_DIM)))
        else $error("store write index beyond the slot size");

endmodule

bind matrix_top matrix_asserts i_matrix_asserts (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .wr       (wr),
    .uart_tx  (uart_tx)
);

`default_nettype wire

// File: dv/tb_matrix_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module tb_matrix_top;
    import link_pkg::*;

    localparam int          SEED         = 32'h1a11e309;
    localparam int          NUM_ENTRIES  = 16;
    // longest command is a 3x3 store, longest reply a 3x3 result
    localparam int          MAX_CMD      = 12;
    localparam int          MAX_REPLY    = 10;
    localparam int          FRAME_CYCLES = 10 * `CLKS_PER_BIT;
    // a reply byte never holds the line high this long
    localparam int          IDLE_CYCLES  = 2 * FRAME_CYCLES;
    localparam int          FRAMES_PER_ENTRY = MAX_CMD + MAX_REPLY + 3;
    localparam int          WATCHDOG_CYCLES  =
                            NUM_ENTRIES * FRAMES_PER_ENTRY * FRAME_CYCLES + 1000;

    logic clk;
    logic arst_n;
    logic rx_line;
    logic tx_line;

    // command table filled by the model before the run
    byte_t cmd_bytes [NUM_ENTRIES][MAX_CMD];
    int    cmd_len   [NUM_ENTRIES];
    byte_t exp_bytes [NUM_ENTRIES][MAX_REPLY];
    int    exp_len   [NUM_ENTRIES];
    string cmd_name  [NUM_ENTRIES];
    int    n_entries;

    // reference model of the slots and k
    bit    mdl_valid [`NUM_SLOTS];
    int    mdl_m     [`NUM_SLOTS];
    int    mdl_n     [`NUM_SLOTS];
    int    mdl_elem  [`NUM_SLOTS][`MAX_DIM * `MAX_DIM];
    int    mdl_k;

    // bytes seen on the DUT serial output
    byte_t replies [$];

    matrix_top i_matrix_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .uart_rx (rx_line),
        .uart_tx (tx_line)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // =========================================================================
    // table building and reference model
    // =========================================================================
    task automatic begin_entry(input string name);
        cmd_len[n_entries]  = 0;
        exp_len[n_entries]  = 0;
        cmd_name[n_entries] = name;
    endtask

    task automatic push_cmd(input byte_t b);
        cmd_bytes[n_entries][cmd_len[n_entries]] = b;
        cmd_len[n_entries]++;
    endtask

    // keeps the low 8 bits like the reply on the wire
    task automatic push_exp(input int v);
        exp_bytes[n_entries][exp_len[n_entries]] = v[7:0];
        exp_len[n_entries]++;
    endtask

    task automatic add_store(input int id, input byte_t dims);
        int          m;
        int          n;
        logic [31:0] rnd;
        begin_entry("STORE");
        m = int'(dims[7:4]);
        n = int'(dims[3:0]);
        push_cmd(OPC_STORE);
        push_cmd(id[7:0]);
        push_cmd(dims);
        // bad id or dims leave the slot contents as they were
        if (id >= `NUM_SLOTS || m == 0 || m > `MAX_DIM || n == 0 || n > `MAX_DIM) begin
            push_exp(int'(`REPLY_ERROR));
        end else begin
            for (int i = 0; i < m * n; i++) begin
                rnd = $urandom();
                push_cmd(rnd[7:0]);
                mdl_elem[id][i] = int'($signed(rnd[7:0]));
            end
            mdl_m[id]     = m;
            mdl_n[id]     = n;
            mdl_valid[id] = 1'b1;
        end
        n_entries++;
    endtask

    // no reply for a new k
    task automatic add_scalar(input byte_t v);
        begin_entry("SCALAR");
        push_cmd(OPC_SCALAR);
        push_cmd(v);
        mdl_k = int'($signed(v));
        n_entries++;
    endtask

    task automatic add_op(input string name, input byte_t opc, input int a, input int b);
        int m;
        int n;
        bit ok;
        begin_entry(name);
        push_cmd(opc);
        push_cmd(a[7:0]);
        if (opc == OPC_ADD) begin
            push_cmd(b[7:0]);
        end
        ok = mdl_valid[a];
        if (opc == OPC_ADD) begin
            ok = ok && mdl_valid[b] && mdl_m[a] == mdl_m[b] && mdl_n[a] == mdl_n[b];
        end
        if (!ok) begin
            push_exp(int'(`REPLY_ERROR));
        end else begin
            // transpose swaps rows and columns
            m = (opc == OPC_TRANSPOSE) ? mdl_n[a] : mdl_m[a];
            n = (opc == OPC_TRANSPOSE) ? mdl_m[a] : mdl_n[a];
            push_exp(m * 16 + n);
            for (int r = 0; r < m; r++) begin
                for (int c = 0; c < n; c++) begin
                    if (opc == OPC_ADD) begin
                        push_exp(mdl_elem[a][r * n + c] + mdl_elem[b][r * n + c]);
                    end else if (opc == OPC_SCALE) begin
                        push_exp(mdl_elem[a][r * n + c] * mdl_k);
                    end else begin
                        // source element at (c, r)
                        push_exp(mdl_elem[a][c * mdl_n[a] + r]);
                    end
                end
            end
        end
        n_entries++;
    endtask

    // =========================================================================
    // serial host
    // =========================================================================
    // start bit, data lsb first, stop bit
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // line sampled on the falling clock edge away from its updates
    task automatic wait_line_idle();
        int quiet;
        quiet = 0;
        while (quiet < IDLE_CYCLES) begin
            @(negedge clk);
            if (tx_line) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic check_reply(input int e);
        assert (replies.size() == exp_len[e])
        else stop_with_error($sformatf(
            "FAIL %0t: %s entry %0d gave %0d reply bytes, expected %0d",
            $time, cmd_name[e], e, replies.size(), exp_len[e]));
        for (int i = 0; i < exp_len[e]; i++) begin
            assert (replies[i] == exp_bytes[e][i])
            else stop_with_error($sformatf(
                "FAIL %0t: %s entry %0d byte %0d is %02h, expected %02h",
                $time, cmd_name[e], e, i, replies[i], exp_bytes[e][i]));
        end
    endtask

    // sampled 3.5 cycles into each bit
    initial begin : reply_decoder
        byte_t b;
        b = '0;
        forever begin
            @(negedge clk);
            if (arst_n && !tx_line) begin
                repeat (`CLKS_PER_BIT / 2 - 1) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (`CLKS_PER_BIT) @(negedge clk);
                    b = {tx_line, b[7:1]};
                end
                repeat (`CLKS_PER_BIT) @(negedge clk);
                assert (tx_line)
                else stop_with_error($sformatf(
                    "FAIL %0t: stop bit low after reply byte %02h", $time, b));
                replies.push_back(b);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error($sformatf(
            "watchdog timeout, the command table did not finish in %0d cycles",
            WATCHDOG_CYCLES));
    end

    // =========================================================================
    // main sequence
    // =========================================================================
    initial begin : run_table
        rx_line   = 1'b1;
        arst_n    = 1'b0;
        n_entries = 0;
        mdl_k     = `DEFAULT_SCALAR;
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            mdl_valid[s] = 1'b0;
            mdl_m[s]     = 0;
            mdl_n[s]     = 0;
        end
        void'($urandom(SEED));

        // add, scale with default and new k, transpose
        add_store(0, 8'h23);
        add_store(1, 8'h23);
        add_op("ADD", OPC_ADD, 0, 1);
        add_op("SCALE", OPC_SCALE, 0, 0);
        add_scalar(8'hFB);
        add_op("SCALE", OPC_SCALE, 0, 0);
        add_op("TRANSPOSE", OPC_TRANSPOSE, 0, 0);
        // illegal requests
        add_store(2, 8'h31);
        add_op("ADD", OPC_ADD, 0, 2);
        add_op("SCALE", OPC_SCALE, 3, 3);
        add_store(5, 8'h22);
        add_store(0, 8'h40);
        // slot 0 must survive the rejected stores
        add_op("SCALE", OPC_SCALE, 0, 0);
        add_op("TRANSPOSE", OPC_TRANSPOSE, 2, 2);
        add_store(1, 8'h33);
        add_op("ADD", OPC_ADD, 1, 1);

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        for (int e = 0; e < n_entries; e++) begin
            replies.delete();
            for (int i = 0; i < cmd_len[e]; i++) begin
                send_byte(cmd_bytes[e][i]);
            end
            wait_line_idle();
            check_reply(e);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_matrix_top -o sim_matrix_top

./obj_dir/sim_matrix_top

// File: sim.f
+incdir+src
src/link_pkg.sv
src/matrix_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_parser.sv
src/matrix_store.sv
src/mat_alu.sv
src/matrix_top.sv
dv/matrix_asserts.sv
dv/tb_matrix_top.sv

// File: src/cmd_parser.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module cmd_parser (
    input  logic                  clk,
    input  logic                  arst_n,
    input  link_pkg::byte_t       rx_byte,
    input  logic                  rx_valid,
    input  logic                  alu_busy,
    output matrix_pkg::store_wr_t wr,
    output matrix_pkg::op_req_t   req
);
    import link_pkg::*;
    import matrix_pkg::*;

    typedef enum logic [1:0] {
        P_OPCODE,
        P_ARG,
        P_ELEM
    } parse_state_e;

    parse_state_e state;
    opcode_e      opcode;
    // second argument byte pending
    logic         arg_cnt;
    slot_t        slot_a;
    logic         bad_id;
    dims_t        dims;
    elem_idx_t    idx;
    elem_idx_t    last_idx;
    // scalar k, copied into every request
    elem_t        k;
    logic         byte_ok;
    logic         dims_bad;

    // bytes are dropped while a reply is in flight
    assign byte_ok  = rx_valid && !alu_busy;
    assign dims_bad = (rx_byte[7:4] == 4'd0) || (rx_byte[7:4] > 4'(`MAX_DIM)) ||
                      (rx_byte[3:0] == 4'd0) || (rx_byte[3:0] > 4'(`MAX_DIM));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= P_OPCODE;
            opcode   <= OPC_STORE;
            arg_cnt  <= 1'b0;
            slot_a   <= '0;
            bad_id   <= 1'b0;
            dims     <= '0;
            idx      <= '0;
            last_idx <= '0;
            k        <= elem_t'(`DEFAULT_SCALAR);
            wr       <= '0;
            req      <= '0;
        end else begin
            wr.valid  <= 1'b0;
            req.valid <= 1'b0;
            if (byte_ok) begin
                case (state)
                    // =========================================================================
                    // opcode byte, unknown opcodes are ignored
                    // =========================================================================
                    P_OPCODE: begin
                        opcode  <= opcode_e'(rx_byte);
                        arg_cnt <= 1'b0;
                        case (rx_byte)
                            OPC_STORE, OPC_SCALAR, OPC_ADD, OPC_SCALE, OPC_TRANSPOSE:
                                state <= P_ARG;
                            default:
                                state <= P_OPCODE;
                        endcase
                    end
                    // =========================================================================
                    // argument bytes
                    // =========================================================================
                    P_ARG: begin
                        arg_cnt <= 1'b1;
                        case (opcode)
                            OPC_SCALAR: begin
                                k     <= elem_t'(rx_byte);
                                state <= P_OPCODE;
                            end
                            OPC_STORE: begin
                                if (!arg_cnt) begin
                                    slot_a <= slot_t'(rx_byte);
                                    bad_id <= (rx_byte >= 8'(`NUM_SLOTS));
                                end else if (bad_id || dims_bad) begin
                                    // ALU answers the error byte
                                    req   <= '{valid: 1'b1, op: OP_REJECT, slot_a: slot_a,
                                               slot_b: slot_a, scalar: k};
                                    state <= P_OPCODE;
                                end else begin
                                    dims     <= '{m: rx_byte[5:4], n: rx_byte[1:0]};
                                    last_idx <= elem_idx_t'(rx_byte[5:4]) *
                                                elem_idx_t'(rx_byte[1:0]) - 4'd1;
                                    idx      <= '0;
                                    state    <= P_ELEM;
                                end
                            end
                            OPC_ADD: begin
                                if (!arg_cnt) begin
                                    slot_a <= slot_t'(rx_byte);
                                end else begin
                                    req   <= '{valid: 1'b1, op: OP_ADD, slot_a: slot_a,
                                               slot_b: slot_t'(rx_byte), scalar: k};
                                    state <= P_OPCODE;
                                end
                            end
                            // scale or transpose, single operand
                            default: begin
                                req   <= '{valid: 1'b1,
                                           op: (opcode == OPC_SCALE) ? OP_SCALE : OP_TRANSPOSE,
                                           slot_a: slot_t'(rx_byte),
                                           slot_b: slot_t'(rx_byte), scalar: k};
                                state <= P_OPCODE;
                            end
                        endcase
                    end
                    // one storage write per element byte
                    P_ELEM: begin
                        wr  <= '{valid: 1'b1, slot: slot_a, idx: idx, data: elem_t'(rx_byte),
                                 dims: dims, last: (idx == last_idx)};
                        idx <= idx + 1'b1;
                        if (idx == last_idx) begin
                            state <= P_OPCODE;
                        end
                    end
                    default: state <= P_OPCODE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/link_pkg.sv
`default_nettype none

package link_pkg;

    // one byte on the serial wire
    typedef logic [7:0] byte_t;

    // first byte of every command
    typedef enum logic [7:0] {
        // slot id, dimension byte, then m*n elements
        OPC_STORE     = 8'h01,
        // one signed byte for k
        OPC_SCALAR    = 8'h02,
        // two slot ids
        OPC_ADD       = 8'h10,
        OPC_SCALE     = 8'h11,
        OPC_TRANSPOSE = 8'h12
    } opcode_e;

    // frame phases, rx and tx alike
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

`default_nettype wire

// File: src/mat_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module mat_alu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  matrix_pkg::op_req_t   req,
    output logic                  alu_busy,
    output matrix_pkg::slot_t     rd_slot,
    output matrix_pkg::elem_idx_t rd_idx,
    input  matrix_pkg::elem_t     rd_data,
    input  matrix_pkg::dims_t     rd_dims,
    input  logic                  rd_slot_valid,
    output link_pkg::byte_t       tx_byte,
    output logic                  tx_start,
    input  logic                  tx_busy
);
    import link_pkg::*;
    import matrix_pkg::*;

    alu_state_e state;
    op_e        op;
    slot_t      slot_a;
    slot_t      slot_b;
    elem_t      k;
    // source dims of slot a, result dims after a possible swap
    dims_t      src;
    dims_t      res;
    // output position, row-major
    dim_t       row;
    dim_t       col;
    elem_t      a_q;
    elem_t      result;
    logic       tx_ready;
    logic       last_pos;

    // tx_busy lags tx_start by a cycle
    assign tx_ready = !tx_busy && !tx_start;
    assign alu_busy = (state != A_IDLE);
    assign last_pos = (row == res.m - 1'b1) && (col == res.n - 1'b1);

    // operand b only while fetching or holding the second element of an add
    assign rd_slot = (op == OP_ADD && (state == A_CHK_B || state == A_RD_B ||
                      state == A_SEND)) ? slot_b : slot_a;
    // transpose reads source (col, row)
    assign rd_idx  = (op == OP_TRANSPOSE) ?
                     elem_idx_t'(col) * elem_idx_t'(src.n) + elem_idx_t'(row) :
                     elem_idx_t'(row) * elem_idx_t'(src.n) + elem_idx_t'(col);

    // 8-bit arithmetic keeps the low byte
    always_comb begin
        case (op)
            OP_ADD:   result = a_q + rd_data;
            OP_SCALE: result = a_q * k;
            default:  result = a_q;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= A_IDLE;
            op       <= OP_REJECT;
            slot_a   <= '0;
            slot_b   <= '0;
            k        <= '0;
            src      <= '0;
            res      <= '0;
            row      <= '0;
            col      <= '0;
            a_q      <= '0;
            tx_byte  <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                A_IDLE: begin
                    if (req.valid) begin
                        op     <= req.op;
                        slot_a <= req.slot_a;
                        slot_b <= req.slot_b;
                        k      <= req.scalar;
                        state  <= (req.op == OP_REJECT) ? A_ERR : A_CHK_A;
                    end
                end
                // =========================================================================
                // operand checks
                // =========================================================================
                A_CHK_A: begin
                    src <= rd_dims;
                    res <= (op == OP_TRANSPOSE) ? dims_t'{m: rd_dims.n, n: rd_dims.m} : rd_dims;
                    if (!rd_slot_valid) begin
                        state <= A_ERR;
                    end else begin
                        state <= (op == OP_ADD) ? A_CHK_B : A_DIM;
                    end
                end
                A_CHK_B: state <= (rd_slot_valid && rd_dims == src) ? A_DIM : A_ERR;
                A_ERR: begin
                    if (tx_ready) begin
                        tx_byte  <= `REPLY_ERROR;
                        tx_start <= 1'b1;
                        state    <= A_FIN;
                    end
                end
                // =========================================================================
                // reply stream, dimension byte then elements
                // =========================================================================
                A_DIM: begin
                    if (tx_ready) begin
                        tx_byte  <= {2'b00, res.m, 2'b00, res.n};
                        tx_start <= 1'b1;
                        row      <= '0;
                        col      <= '0;
                        state    <= A_RD_A;
                    end
                end
                // fetch overlaps the previous byte on the line
                A_RD_A: state <= A_RD_B;
                A_RD_B: begin
                    a_q   <= rd_data;
                    state <= A_SEND;
                end
                A_SEND: begin
                    if (tx_ready) begin
                        tx_byte  <= result;
                        tx_start <= 1'b1;
                        if (last_pos) begin
                            state <= A_FIN;
                        end else begin
                            state <= A_RD_A;
                            if (col == res.n - 1'b1) begin
                                col <= '0;
                                row <= row + 1'b1;
                            end else begin
                                col <= col + 1'b1;
                            end
                        end
                    end
                end
                // busy holds until the last byte is out
                A_FIN: begin
                    if (tx_ready) begin
                        state <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/matrix_config.svh
`ifndef MATRIX_CONFIG_SVH
`define MATRIX_CONFIG_SVH

// serial bit period in clock cycles
`define CLKS_PER_BIT 8

// storage geometry
`define NUM_SLOTS 4
`define MAX_DIM 3

// scalar k after reset
`define DEFAULT_SCALAR 3

// single reply byte for an illegal request
`define REPLY_ERROR 8'hEE

`endif

// File: src/matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    typedef logic signed [7:0] elem_t;
    // row or column count, 1 to 3
    typedef logic [1:0] dim_t;
    typedef logic [1:0] slot_t;
    // row-major element index
    typedef logic [3:0] elem_idx_t;

    // on the wire m sits in the high nibble, n in the low
    typedef struct packed {
        dim_t m;
        dim_t n;
    } dims_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SCALE,
        OP_TRANSPOSE,
        OP_REJECT
    } op_e;

    // store write port, one element per cycle
    typedef struct packed {
        logic      valid;
        slot_t     slot;
        elem_idx_t idx;
        elem_t     data;
        dims_t     dims;
        // final element, makes the slot valid
        logic      last;
    } store_wr_t;

    typedef struct packed {
        logic  valid;
        op_e   op;
        slot_t slot_a;
        slot_t slot_b;
        elem_t scalar;
    } op_req_t;

    typedef enum logic [3:0] {
        A_IDLE,
        A_CHK_A,
        A_CHK_B,
        A_ERR,
        A_DIM,
        A_RD_A,
        A_RD_B,
        A_SEND,
        A_FIN
    } alu_state_e;

endpackage

`default_nettype wire

// File: src/matrix_store.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module matrix_store (
    input  logic                  clk,
    input  logic                  arst_n,
    input  matrix_pkg::store_wr_t wr,
    input  matrix_pkg::slot_t     rd_slot,
    input  matrix_pkg::elem_idx_t rd_idx,
    output matrix_pkg::elem_t     rd_data,
    output matrix_pkg::dims_t     rd_dims,
    output logic                  rd_slot_valid
);
    import matrix_pkg::*;

    localparam int SLOT_ELEMS = `MAX_DIM * `MAX_DIM;

    // row-major elements per slot
    elem_t                 mem [`NUM_SLOTS][SLOT_ELEMS];
    dims_t                 dims_q [`NUM_SLOTS];
    logic [`NUM_SLOTS-1:0] valid_q;

    // one-cycle read latency
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.slot][wr.idx] <= wr.data;
        end
        rd_data <= mem[rd_slot][rd_idx];
    end

    // first element of a store drops the flag, last one sets it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            for (int s = 0; s < `NUM_SLOTS; s++) begin
                dims_q[s] <= '0;
            end
        end else if (wr.valid) begin
            dims_q[wr.slot]  <= wr.dims;
            valid_q[wr.slot] <= wr.last;
        end
    end

    // dimension and valid lookups are combinational
    assign rd_dims       = dims_q[rd_slot];
    assign rd_slot_valid = valid_q[rd_slot];

endmodule

`default_nettype wire

// File: src/matrix_top.sv
`timescale 1ns/1ns
`default_nettype none

module matrix_top (
    input  logic clk,
    input  logic arst_n,
    input  logic uart_rx,
    output logic uart_tx
);
    import link_pkg::*;
    import matrix_pkg::*;

    // serial input path
    byte_t     rx_byte;
    logic      rx_valid;

    // parser to storage and ALU
    store_wr_t wr;
    op_req_t   req;
    logic      alu_busy;

    // ALU read port
    slot_t     rd_slot;
    elem_idx_t rd_idx;
    elem_t     rd_data;
    dims_t     rd_dims;
    logic      rd_slot_valid;

    // reply path
    byte_t     tx_byte;
    logic      tx_start;
    logic      tx_busy;

    uart_rx i_uart_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_parser i_cmd_parser (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .alu_busy (alu_busy),
        .wr       (wr),
        .req      (req)
    );

    matrix_store i_matrix_store (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (wr),
        .rd_slot       (rd_slot),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .rd_dims       (rd_dims),
        .rd_slot_valid (rd_slot_valid)
    );

    mat_alu i_mat_alu (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .alu_busy      (alu_busy),
        .rd_slot       (rd_slot),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .rd_dims       (rd_dims),
        .rd_slot_valid (rd_slot_valid),
        .tx_byte       (tx_byte),
        .tx_start      (tx_start),
        .tx_busy       (tx_busy)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (uart_tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module uart_rx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rx,
    output link_pkg::byte_t rx_byte,
    output logic            rx_valid
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    logic             rx_meta;
    logic             rx_sync;
    uart_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             sample;
    byte_t            shreg;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // mid-bit of a data bit
    assign sample = (state == UART_DATA) && (cnt == CNT_W'(`CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= UART_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= UART_START;
                    end
                end
                // recheck at half a bit, a glitch goes back to idle
                UART_START: begin
                    if (cnt == CNT_W'(`CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (sample) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                // stop bit low means framing error, byte dropped
                UART_STOP: begin
                    if (cnt == CNT_W'(`CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx_sync;
                        state    <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (sample) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

    assign rx_byte = shreg;

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none
`include "matrix_config.svh"

module uart_tx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            tx_start,
    input  link_pkg::byte_t tx_byte,
    output logic            tx,
    output logic            tx_busy
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    uart_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             bit_done;
    byte_t            shreg;

    assign bit_done = (cnt == CNT_W'(`CLKS_PER_BIT - 1));
    // rises the cycle after tx_start, falls after the stop bit
    assign tx_busy  = (state != UART_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= UART_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            cnt <= bit_done ? '0 : cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    cnt <= '0;
                    if (tx_start) begin
                        tx    <= 1'b0;
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        tx      <= shreg[0];
                        bit_idx <= '0;
                        state   <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        // next bit is already at shreg[1] before the shift
                        tx      <= (bit_idx == 3'd7) ? 1'b1 : shreg[1];
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_done) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // load on start, shift right per data bit
    always_ff @(posedge clk) begin
        if (state == UART_IDLE && tx_start) begin
            shreg <= tx_byte;
        end else if (state == UART_DATA && bit_done) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire
